//--- sim.f
+incdir+src
+incdir+verif
src/switch_pkg.sv
src/pkt_buffer.sv
src/ingress_writer.sv
src/queue_manager.sv
src/read_arbiter.sv
src/egress_port.sv
src/hydra_switch.sv
verif/tb_hydra.sv

//--- src/egress_port.sv
`timescale 1ns/1ps

module egress_port import switch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  start_cmd_t start_cmd,
    input  rd_rsp_t    rsp,
    output rd_req_t    rd_req,
    output logic       pkt_done,
    output out_beat_t  out_beat
);

    egress_state_t state;
    addr_t         req_addr;
    logic          last_word;

    assign last_word = rsp.vld && rsp.word.last;

    // request held in both walking states until the word comes back
    assign rd_req = '{vld: state != eg_idle, addr: req_addr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= eg_idle;
        end else begin
            case (state)
                eg_idle: begin
                    if (start_cmd.vld) begin
                        state <= eg_fetch;
                    end
                end
                eg_fetch, eg_drain: begin
                    if (last_word) begin
                        state <= eg_idle;
                    end else if (rsp.vld) begin
                        state <= eg_drain;
                    end
                end
                default: begin
                    state <= eg_idle;
                end
            endcase
        end
    end

    // next slot of the chain
    always_ff @(posedge clk) begin
        if (state == eg_idle && start_cmd.vld) begin
            req_addr <= start_cmd.head;
        end else if (rsp.vld && !rsp.word.last) begin
            req_addr <= rsp.next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_beat <= '0;
            pkt_done <= 1'b0;
        end else begin
            out_beat.vld  <= rsp.vld;
            // first word of the chain is the header
            out_beat.sop  <= rsp.vld && state == eg_fetch;
            out_beat.eop  <= last_word;
            out_beat.data <= rsp.word.data;
            pkt_done      <= last_word;
        end
    end

endmodule

//--- src/hydra_switch.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module hydra_switch import switch_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_sop,
    input  logic                       wr_eop,
    input  logic                       wr_vld,
    input  word_t                      wr_data,
    input  logic    [`NUM_PORTS-1:0]   ready,
    output logic    [`NUM_PORTS-1:0]   rd_sop,
    output logic    [`NUM_PORTS-1:0]   rd_eop,
    output logic    [`NUM_PORTS-1:0]   rd_vld,
    output word_t   [`NUM_PORTS-1:0]   rd_data,
    output logic                       full
);

    // ingress to buffer and queues
    logic       wr_en;
    logic       link_en;
    addr_t      link_prev;
    addr_t      free_addr;
    buf_word_t  wr_word;
    join_req_t  join_req;

    // queues to egress
    start_cmd_t [`NUM_PORTS-1:0] start_cmd;
    logic       [`NUM_PORTS-1:0] pkt_done;

    // shared read path
    rd_req_t    [`NUM_PORTS-1:0] rd_req;
    rd_rsp_t    [`NUM_PORTS-1:0] grant_rsp;
    logic                        rd_en;
    addr_t                       rd_addr;
    rd_rsp_t                     rd_rsp;
    out_beat_t  [`NUM_PORTS-1:0] out_beat;

    pkt_buffer pkt_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_word   (wr_word),
        .link_en   (link_en),
        .link_prev (link_prev),
        .free_addr (free_addr),
        .full      (full),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_rsp    (rd_rsp)
    );

    ingress_writer ingress_writer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_sop    (wr_sop),
        .wr_eop    (wr_eop),
        .wr_vld    (wr_vld),
        .wr_data   (wr_data),
        .free_addr (free_addr),
        .full      (full),
        .wr_en     (wr_en),
        .link_en   (link_en),
        .link_prev (link_prev),
        .wr_word   (wr_word),
        .join_req  (join_req)
    );

    queue_manager queue_manager_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .join_req  (join_req),
        .ready     (ready),
        .pkt_done  (pkt_done),
        .start_cmd (start_cmd)
    );

    read_arbiter read_arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (rd_req),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_rsp_in (rd_rsp),
        .grant_rsp (grant_rsp)
    );

    genvar p;
    generate
        for (p = 0; p < `NUM_PORTS; p++) begin : g_egress
            egress_port egress_port_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .start_cmd (start_cmd[p]),
                .rsp       (grant_rsp[p]),
                .rd_req    (rd_req[p]),
                .pkt_done  (pkt_done[p]),
                .out_beat  (out_beat[p])
            );

            assign rd_sop[p]  = out_beat[p].sop;
            assign rd_eop[p]  = out_beat[p].eop;
            assign rd_vld[p]  = out_beat[p].vld;
            assign rd_data[p] = out_beat[p].data;
        end
    endgenerate

endmodule

//--- src/ingress_writer.sv
`timescale 1ns/1ps

module ingress_writer import switch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_sop,
    input  logic      wr_eop,
    input  logic      wr_vld,
    input  word_t     wr_data,
    input  addr_t     free_addr,
    input  logic      full,
    output logic      wr_en,
    output logic      link_en,
    output addr_t     link_prev,
    output buf_word_t wr_word,
    output join_req_t join_req
);

    ingress_state_t state;
    logic           accept;
    logic           first_q;
    logic           eop_q;
    port_t          dest;
    prior_t         prior;
    addr_t          head_addr;
    addr_t          prev_addr;

    // sop opens a packet from any state
    assign accept = wr_vld && !full && (wr_sop || state == ing_body);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ing_idle;
        end else if (wr_vld) begin
            if (full && (wr_sop || state == ing_body)) begin
                state <= wr_eop ? ing_idle : ing_drop;
            end else if (accept) begin
                state <= wr_eop ? ing_idle : ing_body;
            end else if (wr_eop) begin
                state <= ing_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            link_en <= 1'b0;
        end else begin
            wr_en   <= accept;
            link_en <= accept && !wr_sop;
        end
    end

    // beat held for its write one cycle later
    always_ff @(posedge clk) begin
        wr_word <= '{last: wr_eop, data: wr_data};
        first_q <= wr_sop;
        eop_q   <= wr_eop;
        if (accept && wr_sop) begin
            dest  <= wr_data[1:0];
            prior <= wr_data[6:4];
        end
    end

    // slot taken by the write in flight
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prev_addr <= free_addr;
            if (first_q) begin
                head_addr <= free_addr;
            end
        end
    end

    assign link_prev = prev_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            join_req <= '0;
        end else begin
            join_req.vld   <= wr_en && eop_q;
            join_req.dest  <= dest;
            join_req.prior <= prior;
            // single word packet: head is the slot written now
            join_req.head  <= first_q ? free_addr : head_addr;
        end
    end

endmodule

//--- src/pkt_buffer.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module pkt_buffer import switch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  buf_word_t wr_word,
    input  logic      link_en,
    input  addr_t     link_prev,
    output addr_t     free_addr,
    output logic      full,
    input  logic      rd_en,
    input  addr_t     rd_addr,
    output rd_rsp_t   rd_rsp
);

    localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

    buf_word_t word_mem [`BUF_DEPTH];
    addr_t     next_mem [`BUF_DEPTH];

    // ring of unused slots, popped by writes and refilled by reads
    addr_t            free_ring [`BUF_DEPTH];
    addr_t            free_rd_ptr;
    addr_t            free_wr_ptr;
    logic [CNT_W-1:0] free_cnt;

    logic      rsp_vld;
    buf_word_t rsp_word;
    addr_t     rsp_next;

    assign free_addr = free_ring[free_rd_ptr];
    assign full      = (free_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // every slot starts out free
            for (int i = 0; i < `BUF_DEPTH; i++) begin
                free_ring[i] <= addr_t'(i);
            end
            free_rd_ptr <= '0;
            free_wr_ptr <= '0;
            free_cnt    <= CNT_W'(`BUF_DEPTH);
        end else begin
            if (rd_en) begin
                free_ring[free_wr_ptr] <= rd_addr;
                free_wr_ptr            <= free_wr_ptr + 1'b1;
            end
            if (wr_en) begin
                free_rd_ptr <= free_rd_ptr + 1'b1;
            end
            free_cnt <= free_cnt + CNT_W'(rd_en) - CNT_W'(wr_en);
        end
    end

    // word goes to the free head, which also becomes the next hop of link_prev
    always_ff @(posedge clk) begin
        if (wr_en) begin
            word_mem[free_addr] <= wr_word;
        end
        if (link_en) begin
            next_mem[link_prev] <= free_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        rsp_word <= word_mem[rd_addr];
        rsp_next <= next_mem[rd_addr];
    end

    assign rd_rsp = '{vld: rsp_vld, word: rsp_word, next: rsp_next};

endmodule

//--- src/queue_manager.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module queue_manager import switch_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  join_req_t                     join_req,
    input  logic       [`NUM_PORTS-1:0]   ready,
    input  logic       [`NUM_PORTS-1:0]   pkt_done,
    output start_cmd_t [`NUM_PORTS-1:0]   start_cmd
);

    localparam int PTR_W = $clog2(`DESC_DEPTH);
    localparam int CNT_W = $clog2(`DESC_DEPTH + 1);

    // head-address FIFO per destination and priority
    addr_t            desc_mem [`NUM_PORTS][`NUM_PRIOR][`DESC_DEPTH];
    logic [PTR_W-1:0] wr_ptr   [`NUM_PORTS][`NUM_PRIOR];
    logic [PTR_W-1:0] rd_ptr   [`NUM_PORTS][`NUM_PRIOR];
    logic [CNT_W-1:0] count    [`NUM_PORTS][`NUM_PRIOR];

    logic [`NUM_PORTS-1:0] busy;
    logic [`NUM_PORTS-1:0] pending;
    logic [`NUM_PORTS-1:0] start_go;
    prior_t                sel_prior [`NUM_PORTS];
    logic [`NUM_PRIOR-1:0] push      [`NUM_PORTS];
    logic [`NUM_PRIOR-1:0] pop       [`NUM_PORTS];
    logic [PTR_W-1:0]      join_slot;

    assign join_slot = wr_ptr[join_req.dest][join_req.prior];

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            pending[p]   = 1'b0;
            sel_prior[p] = '0;
            // ascending scan, so the highest non-empty priority is kept
            for (int q = 0; q < `NUM_PRIOR; q++) begin
                if (count[p][q] != '0) begin
                    pending[p]   = 1'b1;
                    sel_prior[p] = prior_t'(q);
                end
            end
            start_go[p] = ready[p] && !busy[p] && pending[p];
            for (int q = 0; q < `NUM_PRIOR; q++) begin
                push[p][q] = join_req.vld && join_req.dest == port_t'(p)
                             && join_req.prior == prior_t'(q);
                pop[p][q]  = start_go[p] && sel_prior[p] == prior_t'(q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                for (int q = 0; q < `NUM_PRIOR; q++) begin
                    wr_ptr[p][q] <= '0;
                    rd_ptr[p][q] <= '0;
                    count[p][q]  <= '0;
                end
            end
            busy <= '0;
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                for (int q = 0; q < `NUM_PRIOR; q++) begin
                    if (push[p][q]) begin
                        wr_ptr[p][q] <= wr_ptr[p][q] + 1'b1;
                    end
                    if (pop[p][q]) begin
                        rd_ptr[p][q] <= rd_ptr[p][q] + 1'b1;
                    end
                    count[p][q] <= count[p][q] + CNT_W'(push[p][q]) - CNT_W'(pop[p][q]);
                end
                // busy from start until the port reports its packet done
                if (start_go[p]) begin
                    busy[p] <= 1'b1;
                end else if (pkt_done[p]) begin
                    busy[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (join_req.vld) begin
            desc_mem[join_req.dest][join_req.prior][join_slot] <= join_req.head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cmd <= '0;
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                start_cmd[p].vld  <= start_go[p];
                start_cmd[p].head <= desc_mem[p][sel_prior[p]][rd_ptr[p][sel_prior[p]]];
            end
        end
    end

endmodule

//--- src/read_arbiter.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module read_arbiter import switch_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rd_req_t [`NUM_PORTS-1:0]   rd_req,
    output logic                       rd_en,
    output addr_t                      rd_addr,
    input  rd_rsp_t                    rd_rsp_in,
    output rd_rsp_t [`NUM_PORTS-1:0]   grant_rsp
);

    port_t                 rr_ptr;
    port_t                 winner;
    port_t                 cand;
    port_t                 win_q;
    logic                  gnt_q;
    logic [`NUM_PORTS-1:0] req_live;

    always_comb begin
        rd_en  = 1'b0;
        winner = rr_ptr;
        cand   = rr_ptr;
        // last cycle's winner still shows its old request while the word returns
        for (int p = 0; p < `NUM_PORTS; p++) begin
            req_live[p] = rd_req[p].vld && !(gnt_q && win_q == port_t'(p));
        end
        for (int i = 0; i < `NUM_PORTS; i++) begin
            cand = rr_ptr + port_t'(i);
            if (!rd_en && req_live[cand]) begin
                rd_en  = 1'b1;
                winner = cand;
            end
        end
    end

    assign rd_addr = rd_req[winner].addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            win_q  <= '0;
            gnt_q  <= 1'b0;
        end else begin
            gnt_q <= rd_en;
            win_q <= winner;
            if (rd_en) begin
                rr_ptr <= winner + 1'b1;
            end
        end
    end

    // response only marked valid toward the port that won
    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            grant_rsp[p]     = rd_rsp_in;
            grant_rsp[p].vld = rd_rsp_in.vld && gnt_q && win_q == port_t'(p);
        end
    end

endmodule

//--- src/switch_defs.svh
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

// egress side
`define NUM_PORTS 4

// priority levels, 7 is the highest
`define NUM_PRIOR 8

// payload word width
`define DATA_W 16

// shared buffer slots and the address width that covers them
`define BUF_DEPTH 64
`define ADDR_W 6

// head addresses held per destination and priority
`define DESC_DEPTH 4

`endif

//--- src/switch_pkg.sv
`include "switch_defs.svh"

package switch_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [1:0]         port_t;
    typedef logic [2:0]         prior_t;
    typedef logic [`DATA_W-1:0] word_t;

    // one buffer slot: payload plus end of packet
    typedef struct packed {
        logic  last;
        word_t data;
    } buf_word_t;

    // finished packet, handed to the queue manager
    typedef struct packed {
        logic   vld;
        port_t  dest;
        prior_t prior;
        addr_t  head;
    } join_req_t;

    typedef struct packed {
        logic  vld;
        addr_t head;
    } start_cmd_t;

    typedef struct packed {
        logic  vld;
        addr_t addr;
    } rd_req_t;

    // word and its next pointer, one cycle after grant
    typedef struct packed {
        logic      vld;
        buf_word_t word;
        addr_t     next;
    } rd_rsp_t;

    typedef struct packed {
        logic  sop;
        logic  eop;
        logic  vld;
        word_t data;
    } out_beat_t;

    typedef enum logic [1:0] {ing_idle, ing_body, ing_drop} ingress_state_t;
    typedef enum logic [1:0] {eg_idle, eg_fetch, eg_drain} egress_state_t;

endpackage

//--- verif/tb_scoreboard.svh
`ifndef TB_SCOREBOARD_SVH
`define TB_SCOREBOARD_SVH

int    data_errors  = 0;
int    proto_errors = 0;
string test_name    = "init";

// expected packets per destination and priority, words kept flat
word_t exp_words [`NUM_PORTS][`NUM_PRIOR][$];
int    exp_lens  [`NUM_PORTS][`NUM_PRIOR][$];

logic [15:0] lfsr_state = 16'd43;

// 16 bit galois lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 16'hB400;
    end
    return n;
endfunction

// one lfsr step per bit
function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[14:0], lfsr_state[0]};
    end
    return v;
endfunction

task automatic compare_value(input string what, input int exp, input int act);
    assert (exp == act) else begin
        data_errors++;
        $display("FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
    end
endtask

// every sent packet should have been delivered by now
task automatic check_drained();
    for (int p = 0; p < `NUM_PORTS; p++) begin
        for (int q = 0; q < `NUM_PRIOR; q++) begin
            assert (exp_lens[p][q].size() == 0) else begin
                proto_errors++;
                $display("%0d packets for port %0d priority %0d never came out",
                         exp_lens[p][q].size(), p, q);
            end
        end
    end
endtask

`endif

//--- verif/tb_hydra.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module tb_hydra import switch_pkg::*; ();

    logic                      clk;
    logic                      rst_n;
    logic                      wr_sop;
    logic                      wr_eop;
    logic                      wr_vld;
    word_t                     wr_data;
    logic    [`NUM_PORTS-1:0]  ready;
    logic    [`NUM_PORTS-1:0]  rd_sop;
    logic    [`NUM_PORTS-1:0]  rd_eop;
    logic    [`NUM_PORTS-1:0]  rd_vld;
    word_t   [`NUM_PORTS-1:0]  rd_data;
    logic                      full;

    int                    sent_total;
    int                    rx_total;
    int                    rx_cnt     [`NUM_PORTS];
    int                    cur_idx    [`NUM_PORTS];
    prior_t                cur_prior  [`NUM_PORTS];
    prior_t                last_prior [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] open_pkt;
    int                    base;

    `include "tb_scoreboard.svh"

    hydra_switch hydra_switch_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .full    (full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // a packet is open from its sop beat until its eop beat
    always @(posedge clk) begin
        if (!rst_n) begin
            open_pkt <= '0;
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (rd_vld[p] && rd_eop[p]) begin
                    open_pkt[p] <= 1'b0;
                end else if (rd_vld[p] && rd_sop[p]) begin
                    open_pkt[p] <= 1'b1;
                end
            end
        end
    end

    for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_checks
        sop_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
                                      rd_sop[g] |-> rd_vld[g])
            else begin
                proto_errors++;
                $display("port %0d raised rd_sop without rd_vld", g);
            end
        eop_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
                                      rd_eop[g] |-> rd_vld[g])
            else begin
                proto_errors++;
                $display("port %0d raised rd_eop without rd_vld", g);
            end
        no_double_sop: assert property (@(posedge clk) disable iff (!rst_n)
                                        rd_sop[g] |-> !open_pkt[g])
            else begin
                proto_errors++;
                $display("port %0d started a packet before the last one ended", g);
            end
    end

    full_low: assert property (@(posedge clk) disable iff (!rst_n) !full)
        else begin
            proto_errors++;
            $display("buffer reported full during %s", test_name);
        end

    // priority in the first word's header names the FIFO whose front packet is due
    always @(negedge clk) begin : collect
        int     len;
        prior_t pr;
        if (rst_n) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (rd_vld[p]) begin
                    if (cur_idx[p] == 0) begin
                        cur_prior[p] = rd_data[p][6:4];
                    end
                    pr  = cur_prior[p];
                    len = (exp_lens[p][pr].size() > 0) ? exp_lens[p][pr][0] : 0;
                    if (len == 0 || cur_idx[p] >= len) begin
                        proto_errors++;
                        $display("unexpected word on port %0d during %s", p, test_name);
                    end else begin
                        compare_value("data", exp_words[p][pr][cur_idx[p]], rd_data[p]);
                        compare_value("sop", cur_idx[p] == 0, rd_sop[p]);
                        compare_value("eop", cur_idx[p] == len - 1, rd_eop[p]);
                    end
                    cur_idx[p]++;
                    if (rd_eop[p]) begin
                        for (int i = 0; i < len; i++) begin
                            void'(exp_words[p][pr].pop_front());
                        end
                        if (len > 0) begin
                            void'(exp_lens[p][pr].pop_front());
                        end
                        last_prior[p] = pr;
                        rx_cnt[p]++;
                        rx_total++;
                        cur_idx[p] = 0;
                    end
                end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // header carries dest in bits 1:0 and priority in bits 6:4
    task automatic send_packet(input port_t dest, input prior_t prior, input int len);
        word_t w;
        for (int i = 0; i < len; i++) begin
            w = take_bits(16);
            if (i == 0) begin
                w[1:0] = dest;
                w[6:4] = prior;
            end
            exp_words[dest][prior].push_back(w);
            wr_vld  = 1'b1;
            wr_sop  = (i == 0);
            wr_eop  = (i == len - 1);
            wr_data = w;
            step();
        end
        exp_lens[dest][prior].push_back(len);
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        sent_total++;
    endtask

    task automatic pulse_ready(input logic [`NUM_PORTS-1:0] mask);
        ready = mask;
        step();
        ready = '0;
    endtask

    task automatic wait_port(input int p, input int target, input int limit);
        int n;
        n = 0;
        while (rx_cnt[p] < target && n < limit) begin
            step();
            n++;
        end
        if (rx_cnt[p] < target) begin
            proto_errors++;
            $display("timeout in %s waiting for packet %0d on port %0d", test_name, target, p);
        end
    endtask

    // strobes that land on a busy or empty port are simply ignored
    task automatic drain(input int limit);
        int n;
        n = 0;
        while (rx_total < sent_total && n < limit) begin
            pulse_ready('1);
            idle(3);
            n++;
        end
        if (rx_total < sent_total) begin
            proto_errors++;
            $display("timeout in %s: %0d of %0d packets delivered",
                     test_name, rx_total, sent_total);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        wr_sop     = 1'b0;
        wr_eop     = 1'b0;
        wr_vld     = 1'b0;
        wr_data    = '0;
        ready      = '0;
        sent_total = 0;
        rx_total   = 0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            rx_cnt[p]  = 0;
            cur_idx[p] = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_name = "reset";
        pulse_ready('1);
        repeat (20) begin
            compare_value("rd_vld", 0, rd_vld);
            compare_value("rd_sop", 0, rd_sop);
            compare_value("rd_eop", 0, rd_eop);
            compare_value("full", 0, full);
            step();
        end

        test_name = "basic";
        for (int len = 1; len <= 8; len++) begin
            send_packet(port_t'(len - 1), prior_t'(0), len);
        end
        idle(3);
        drain(300);

        test_name = "priority";
        base = rx_cnt[1];
        send_packet(port_t'(1), prior_t'(2), 3);
        send_packet(port_t'(1), prior_t'(6), 4);
        idle(3);
        pulse_ready(4'b0010);
        wait_port(1, base + 1, 100);
        compare_value("first priority", 6, last_prior[1]);
        idle(2);
        pulse_ready(4'b0010);
        wait_port(1, base + 2, 100);
        compare_value("second priority", 2, last_prior[1]);

        test_name = "order";
        send_packet(port_t'(2), prior_t'(3), 2);
        send_packet(port_t'(2), prior_t'(3), 5);
        send_packet(port_t'(2), prior_t'(3), 3);
        idle(3);
        drain(300);

        // the first drain strobe hits all four ports with work queued
        test_name = "parallel";
        for (int k = 0; k < 2 * `NUM_PORTS; k++) begin
            send_packet(port_t'(k), prior_t'(take_bits(3)), take_bits(3) + 1);
        end
        idle(3);
        drain(300);

        // ten batches of at most 56 words each cycle through the buffer
        test_name = "reuse";
        for (int b = 0; b < 10; b++) begin
            for (int k = 0; k < 8; k++) begin
                send_packet(port_t'(k), prior_t'(take_bits(3)), take_bits(3) % 7 + 1);
            end
            idle(3);
            drain(300);
        end

        test_name = "final";
        idle(4);
        check_drained();
        $display("errors: %0d data, %0d protocol", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
